//--- coh_bus_pkg.sv
package coh_bus_pkg;

	// ----------------------------------------------------------------------
	// block address and data widths
	// ----------------------------------------------------------------------
	localparam int TAG_W	= 8;
	localparam int IDX_W	= 4;
	// tag and index together name one block
	localparam int BLK_W	= TAG_W + IDX_W;
	localparam int WORD_W	= 64;

	// ----------------------------------------------------------------------
	// response queue
	// ----------------------------------------------------------------------
	localparam int RSP_Q_NUM	= 4;
	localparam int RSP_Q_PTR_W	= 2;

	// ----------------------------------------------------------------------
	// data memory
	// ----------------------------------------------------------------------
	// broadcast to reply, in cycles
	localparam int MEM_LAT		= 4;
	// one word per block address
	localparam int MEM_WORDS	= 4096;

	// bus messages
	typedef enum logic [1:0] {
		// idle bus
		NONE	= 2'd0,
		// read shared
		GET_S	= 2'd1,
		// read for modify
		GET_M	= 2'd2,
		// write back
		PUT_M	= 2'd3
	} message_t;

endpackage : coh_bus_pkg

//--- coh_bus_arbiter.sv
`timescale 1ns/1ps

module coh_bus_arbiter (
	input	logic	clk,
	input	logic	rst,

	// request levels from the cores
	input	logic	core0_req_en_i,
	input	logic	core1_req_en_i,

	// block already pending in the response queue
	input	logic	core0_pend_hit_i,
	input	logic	core1_pend_hit_i,

	// low while the queue is full
	input	logic	grant_en_i,

	output	logic	core0_gnt_o,
	output	logic	core1_gnt_o
);

	// 0 favors core0, 1 favors core1
	logic	prio_r;

	logic	core0_elig;
	logic	core1_elig;

	// a core may win only with a request and no pending hit
	assign core0_elig	= core0_req_en_i & ~core0_pend_hit_i;
	assign core1_elig	= core1_req_en_i & ~core1_pend_hit_i;

	// priority toggles every clock
	always_ff @(posedge clk) begin
		if (rst) begin
			prio_r	<= 1'b0;
		end else begin
			prio_r	<= ~prio_r;
		end
	end

	always_comb begin
		core0_gnt_o	= 1'b0;
		core1_gnt_o	= 1'b0;
		if (grant_en_i) begin
			if (!prio_r) begin
				// core0 favored
				if (core0_elig) begin
					core0_gnt_o	= 1'b1;
				end else if (core1_elig) begin
					core1_gnt_o	= 1'b1;
				end
			end else begin
				// core1 favored
				if (core1_elig) begin
					core1_gnt_o	= 1'b1;
				end else if (core0_elig) begin
					core0_gnt_o	= 1'b1;
				end
			end
		end
	end

	// one bus slot per cycle
	a_one_grant: assert property (@(posedge clk) disable iff (rst)
		!(core0_gnt_o && core1_gnt_o));

endmodule : coh_bus_arbiter

//--- coh_rsp_queue.sv
`timescale 1ns/1ps

module coh_rsp_queue (
	input	logic								clk,
	input	logic								rst,

	// allocation on bus acceptance
	input	logic								alloc_i,
	input	logic								alloc_id_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]		alloc_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]		alloc_idx_i,

	// owner supply, same cycle as the allocation
	input	logic								snoop_vld_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]		snoop_data_i,

	// memory reply, addressed by entry
	input	logic								mem_vld_i,
	input	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	mem_ptr_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]		mem_data_i,

	// blocks the cores are asking for
	input	logic [coh_bus_pkg::TAG_W-1:0]		core0_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]		core0_idx_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]		core1_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]		core1_idx_i,

	output	logic								full_o,
	output	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	tail_o,
	output	logic								core0_pend_hit_o,
	output	logic								core1_pend_hit_o,

	// in-order response drain
	output	logic								rsp_vld_o,
	output	logic								rsp_id_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]		rsp_data_o
);

	// entry payload
	logic [coh_bus_pkg::TAG_W-1:0]		tag_r [coh_bus_pkg::RSP_Q_NUM];
	logic [coh_bus_pkg::IDX_W-1:0]		idx_r [coh_bus_pkg::RSP_Q_NUM];
	logic [coh_bus_pkg::WORD_W-1:0]		data_r [coh_bus_pkg::RSP_Q_NUM];
	logic [coh_bus_pkg::RSP_Q_NUM-1:0]	id_r;

	// entry state
	logic [coh_bus_pkg::RSP_Q_NUM-1:0]	vld_r;
	logic [coh_bus_pkg::RSP_Q_NUM-1:0]	rdy_r;

	// pointers, top bit is the wrap bit
	logic [coh_bus_pkg::RSP_Q_PTR_W:0]		head_r;
	logic [coh_bus_pkg::RSP_Q_PTR_W:0]		tail_r;
	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	head;
	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	tail;

	logic	mem_fill;

	assign head	= head_r[coh_bus_pkg::RSP_Q_PTR_W-1:0];
	assign tail	= tail_r[coh_bus_pkg::RSP_Q_PTR_W-1:0];

	assign full_o	= (head_r[coh_bus_pkg::RSP_Q_PTR_W] != tail_r[coh_bus_pkg::RSP_Q_PTR_W])
					&& (head == tail);
	assign tail_o	= tail;

	// head leaves the first cycle it is ready
	assign rsp_vld_o	= vld_r[head] & rdy_r[head];
	assign rsp_id_o		= id_r[head];
	assign rsp_data_o	= data_r[head];

	// replies to entries already supplied or already freed are dropped
	assign mem_fill	= mem_vld_i & vld_r[mem_ptr_i] & ~rdy_r[mem_ptr_i];

	// ----------------------------------------------------------------------
	// pending block match
	// ----------------------------------------------------------------------
	always_comb begin
		core0_pend_hit_o	= 1'b0;
		core1_pend_hit_o	= 1'b0;
		for (int i = 0; i < coh_bus_pkg::RSP_Q_NUM; i++) begin
			if (vld_r[i] && tag_r[i] == core0_tag_i && idx_r[i] == core0_idx_i) begin
				core0_pend_hit_o	= 1'b1;
			end
			if (vld_r[i] && tag_r[i] == core1_tag_i && idx_r[i] == core1_idx_i) begin
				core1_pend_hit_o	= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// pointers and entry state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r	<= '0;
			tail_r	<= '0;
			vld_r	<= '0;
			rdy_r	<= '0;
		end else begin
			// free the head entry as it goes out
			if (rsp_vld_o) begin
				vld_r[head]	<= 1'b0;
				rdy_r[head]	<= 1'b0;
				head_r		<= head_r + 1'b1;
			end
			if (mem_fill) begin
				rdy_r[mem_ptr_i]	<= 1'b1;
			end
			if (alloc_i) begin
				vld_r[tail]	<= 1'b1;
				// owner data makes the entry ready right away
				rdy_r[tail]	<= snoop_vld_i;
				tail_r		<= tail_r + 1'b1;
			end
		end
	end

	// payload writes
	always_ff @(posedge clk) begin
		if (alloc_i) begin
			tag_r[tail]	<= alloc_tag_i;
			idx_r[tail]	<= alloc_idx_i;
			id_r[tail]	<= alloc_id_i;
			if (snoop_vld_i) begin
				data_r[tail]	<= snoop_data_i;
			end
		end
		if (mem_fill) begin
			data_r[mem_ptr_i]	<= mem_data_i;
		end
	end

	a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
		alloc_i |-> !full_o);

	// every memory reply belongs to the allocation at that entry MEM_LAT cycles back
	a_mem_rsp_owner: assert property (@(posedge clk) disable iff (rst)
		mem_vld_i |-> $past(alloc_i, coh_bus_pkg::MEM_LAT)
			&& $past(tail, coh_bus_pkg::MEM_LAT) == mem_ptr_i);

endmodule : coh_rsp_queue

//--- coh_bus.sv
`timescale 1ns/1ps

module coh_bus (
	input	logic									clk,
	input	logic									rst,

	// core0
	input	logic									core0_req_en_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]			core0_req_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]			core0_req_idx_i,
	input	coh_bus_pkg::message_t					core0_req_message_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core0_req_data_i,
	input	logic									core0_rsp_vld_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core0_rsp_data_i,
	output	logic									bus2core0_req_ack_o,

	// core1
	input	logic									core1_req_en_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]			core1_req_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]			core1_req_idx_i,
	input	coh_bus_pkg::message_t					core1_req_message_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core1_req_data_i,
	input	logic									core1_rsp_vld_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core1_rsp_data_i,
	output	logic									bus2core1_req_ack_o,

	// memory reply
	input	logic									dmem_rsp_vld_i,
	input	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	dmem_rsp_ptr_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			dmem_rsp_data_i,

	// broadcast
	output	logic									bus_req_vld_o,
	output	logic									bus_req_id_o,
	output	logic [coh_bus_pkg::TAG_W-1:0]			bus_req_tag_o,
	output	logic [coh_bus_pkg::IDX_W-1:0]			bus_req_idx_o,
	output	coh_bus_pkg::message_t					bus_req_message_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]			bus_req_data_o,
	output	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	bus_req_ptr_o,

	// responses
	output	logic									bus_rsp_vld_o,
	output	logic									bus_rsp_id_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]			bus_rsp_data_o
);

	logic	q_full;
	logic	core0_gnt;
	logic	core1_gnt;
	logic	core0_pend_hit;
	logic	core1_pend_hit;
	logic	snoop_vld;
	logic [coh_bus_pkg::WORD_W-1:0]	snoop_data;

	coh_bus_arbiter u_arbiter (
		.clk				(clk),
		.rst				(rst),
		.core0_req_en_i		(core0_req_en_i),
		.core1_req_en_i		(core1_req_en_i),
		.core0_pend_hit_i	(core0_pend_hit),
		.core1_pend_hit_i	(core1_pend_hit),
		.grant_en_i			(~q_full),
		.core0_gnt_o		(core0_gnt),
		.core1_gnt_o		(core1_gnt)
	);

	// ----------------------------------------------------------------------
	// acknowledge and broadcast
	// ----------------------------------------------------------------------
	assign bus2core0_req_ack_o	= core0_gnt;
	assign bus2core1_req_ack_o	= core1_gnt;
	assign bus_req_vld_o		= core0_gnt | core1_gnt;
	assign bus_req_id_o			= core1_gnt;

	// idle bus shows NONE with zero payload
	always_comb begin
		bus_req_tag_o		= '0;
		bus_req_idx_o		= '0;
		bus_req_message_o	= coh_bus_pkg::NONE;
		bus_req_data_o		= '0;
		if (core1_gnt) begin
			bus_req_tag_o		= core1_req_tag_i;
			bus_req_idx_o		= core1_req_idx_i;
			bus_req_message_o	= core1_req_message_i;
			bus_req_data_o		= core1_req_data_i;
		end else if (core0_gnt) begin
			bus_req_tag_o		= core0_req_tag_i;
			bus_req_idx_o		= core0_req_idx_i;
			bus_req_message_o	= core0_req_message_i;
			bus_req_data_o		= core0_req_data_i;
		end
	end

	// single owner, so at most one supply
	assign snoop_vld	= core0_rsp_vld_i | core1_rsp_vld_i;
	assign snoop_data	= core1_rsp_vld_i ? core1_rsp_data_i : core0_rsp_data_i;

	coh_rsp_queue u_rsp_queue (
		.clk				(clk),
		.rst				(rst),
		.alloc_i			(bus_req_vld_o),
		.alloc_id_i			(bus_req_id_o),
		.alloc_tag_i		(bus_req_tag_o),
		.alloc_idx_i		(bus_req_idx_o),
		.snoop_vld_i		(snoop_vld),
		.snoop_data_i		(snoop_data),
		.mem_vld_i			(dmem_rsp_vld_i),
		.mem_ptr_i			(dmem_rsp_ptr_i),
		.mem_data_i			(dmem_rsp_data_i),
		.core0_tag_i		(core0_req_tag_i),
		.core0_idx_i		(core0_req_idx_i),
		.core1_tag_i		(core1_req_tag_i),
		.core1_idx_i		(core1_req_idx_i),
		.full_o				(q_full),
		.tail_o				(bus_req_ptr_o),
		.core0_pend_hit_o	(core0_pend_hit),
		.core1_pend_hit_o	(core1_pend_hit),
		.rsp_vld_o			(bus_rsp_vld_o),
		.rsp_id_o			(bus_rsp_id_o),
		.rsp_data_o			(bus_rsp_data_o)
	);

	a_one_owner: assert property (@(posedge clk) disable iff (rst)
		!(core0_rsp_vld_i && core1_rsp_vld_i));

endmodule : coh_bus

//--- dmem_ctrl.sv
`timescale 1ns/1ps

module dmem_ctrl (
	input	logic									clk,
	input	logic									rst,

	// bus broadcast
	input	logic									req_vld_i,
	input	coh_bus_pkg::message_t					req_msg_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]			req_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]			req_idx_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			req_data_i,
	input	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	req_ptr_i,

	// reply to the response queue
	output	logic									rsp_vld_o,
	output	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	rsp_ptr_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]			rsp_data_o
);

	logic [coh_bus_pkg::WORD_W-1:0]		mem [coh_bus_pkg::MEM_WORDS];
	logic [coh_bus_pkg::BLK_W-1:0]		blk_addr;
	logic								is_put;
	logic [coh_bus_pkg::WORD_W-1:0]		rd_data;

	// latency pipeline
	logic [coh_bus_pkg::MEM_LAT-1:0]		vld_pipe_r;
	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	ptr_pipe_r [coh_bus_pkg::MEM_LAT];
	logic [coh_bus_pkg::WORD_W-1:0]			data_pipe_r [coh_bus_pkg::MEM_LAT];

	// each word starts out as its own block address
	initial begin
		for (int i = 0; i < coh_bus_pkg::MEM_WORDS; i++) begin
			mem[i]								= '0;
			mem[i][coh_bus_pkg::BLK_W-1:0]		= i[coh_bus_pkg::BLK_W-1:0];
		end
	end

	assign blk_addr	= {req_tag_i, req_idx_i};
	assign is_put	= (req_msg_i == coh_bus_pkg::PUT_M);
	assign rd_data	= mem[blk_addr];

	// write back at acceptance
	always_ff @(posedge clk) begin
		if (req_vld_i && is_put) begin
			mem[blk_addr]	<= req_data_i;
		end
	end

	// ----------------------------------------------------------------------
	// reply pipeline
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe_r	<= '0;
		end else begin
			vld_pipe_r	<= {vld_pipe_r[coh_bus_pkg::MEM_LAT-2:0], req_vld_i};
		end
	end

	always_ff @(posedge clk) begin
		ptr_pipe_r[0]	<= req_ptr_i;
		// a PUT echoes the data it wrote
		data_pipe_r[0]	<= is_put ? req_data_i : rd_data;
		for (int i = 1; i < coh_bus_pkg::MEM_LAT; i++) begin
			ptr_pipe_r[i]	<= ptr_pipe_r[i-1];
			data_pipe_r[i]	<= data_pipe_r[i-1];
		end
	end

	assign rsp_vld_o	= vld_pipe_r[coh_bus_pkg::MEM_LAT-1];
	assign rsp_ptr_o	= ptr_pipe_r[coh_bus_pkg::MEM_LAT-1];
	assign rsp_data_o	= data_pipe_r[coh_bus_pkg::MEM_LAT-1];

endmodule : dmem_ctrl

//--- coh_bus_top.sv
`timescale 1ns/1ps

module coh_bus_top (
	input	logic									clk,
	input	logic									rst,

	// core0
	input	logic									core0_req_en_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]			core0_req_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]			core0_req_idx_i,
	input	coh_bus_pkg::message_t					core0_req_message_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core0_req_data_i,
	input	logic									core0_rsp_vld_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core0_rsp_data_i,
	output	logic									bus2core0_req_ack_o,

	// core1
	input	logic									core1_req_en_i,
	input	logic [coh_bus_pkg::TAG_W-1:0]			core1_req_tag_i,
	input	logic [coh_bus_pkg::IDX_W-1:0]			core1_req_idx_i,
	input	coh_bus_pkg::message_t					core1_req_message_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core1_req_data_i,
	input	logic									core1_rsp_vld_i,
	input	logic [coh_bus_pkg::WORD_W-1:0]			core1_rsp_data_i,
	output	logic									bus2core1_req_ack_o,

	// broadcast
	output	logic									bus_req_vld_o,
	output	logic									bus_req_id_o,
	output	logic [coh_bus_pkg::TAG_W-1:0]			bus_req_tag_o,
	output	logic [coh_bus_pkg::IDX_W-1:0]			bus_req_idx_o,
	output	coh_bus_pkg::message_t					bus_req_message_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]			bus_req_data_o,
	output	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	bus_req_ptr_o,

	// responses
	output	logic									bus_rsp_vld_o,
	output	logic									bus_rsp_id_o,
	output	logic [coh_bus_pkg::WORD_W-1:0]			bus_rsp_data_o
);

	// memory reply back into the queue
	logic									dmem_rsp_vld;
	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	dmem_rsp_ptr;
	logic [coh_bus_pkg::WORD_W-1:0]			dmem_rsp_data;

	coh_bus u_bus (
		.clk					(clk),
		.rst					(rst),
		.core0_req_en_i			(core0_req_en_i),
		.core0_req_tag_i		(core0_req_tag_i),
		.core0_req_idx_i		(core0_req_idx_i),
		.core0_req_message_i	(core0_req_message_i),
		.core0_req_data_i		(core0_req_data_i),
		.core0_rsp_vld_i		(core0_rsp_vld_i),
		.core0_rsp_data_i		(core0_rsp_data_i),
		.bus2core0_req_ack_o	(bus2core0_req_ack_o),
		.core1_req_en_i			(core1_req_en_i),
		.core1_req_tag_i		(core1_req_tag_i),
		.core1_req_idx_i		(core1_req_idx_i),
		.core1_req_message_i	(core1_req_message_i),
		.core1_req_data_i		(core1_req_data_i),
		.core1_rsp_vld_i		(core1_rsp_vld_i),
		.core1_rsp_data_i		(core1_rsp_data_i),
		.bus2core1_req_ack_o	(bus2core1_req_ack_o),
		.dmem_rsp_vld_i			(dmem_rsp_vld),
		.dmem_rsp_ptr_i			(dmem_rsp_ptr),
		.dmem_rsp_data_i		(dmem_rsp_data),
		.bus_req_vld_o			(bus_req_vld_o),
		.bus_req_id_o			(bus_req_id_o),
		.bus_req_tag_o			(bus_req_tag_o),
		.bus_req_idx_o			(bus_req_idx_o),
		.bus_req_message_o		(bus_req_message_o),
		.bus_req_data_o			(bus_req_data_o),
		.bus_req_ptr_o			(bus_req_ptr_o),
		.bus_rsp_vld_o			(bus_rsp_vld_o),
		.bus_rsp_id_o			(bus_rsp_id_o),
		.bus_rsp_data_o			(bus_rsp_data_o)
	);

	// memory sees every broadcast
	dmem_ctrl u_dmem_ctrl (
		.clk			(clk),
		.rst			(rst),
		.req_vld_i		(bus_req_vld_o),
		.req_msg_i		(bus_req_message_o),
		.req_tag_i		(bus_req_tag_o),
		.req_idx_i		(bus_req_idx_o),
		.req_data_i		(bus_req_data_o),
		.req_ptr_i		(bus_req_ptr_o),
		.rsp_vld_o		(dmem_rsp_vld),
		.rsp_ptr_o		(dmem_rsp_ptr),
		.rsp_data_o		(dmem_rsp_data)
	);

endmodule : coh_bus_top

//--- coh_bus_tb.sv
`timescale 1ns/1ps

module coh_bus_tb;

	localparam int RND_REQS		= 200;
	// directed requests plus the random mix
	localparam int TOTAL_REQS	= 6 + RND_REQS;
	localparam int WATCH_CYC	= TOTAL_REQS
		* (coh_bus_pkg::MEM_LAT + coh_bus_pkg::RSP_Q_NUM + 20) + 20;

	typedef struct packed {
		coh_bus_pkg::message_t				msg;
		logic [coh_bus_pkg::BLK_W-1:0]		blk;
		logic [coh_bus_pkg::WORD_W-1:0]		data;
	} req_t;

	typedef struct packed {
		logic [coh_bus_pkg::BLK_W-1:0]		blk;
		logic								id;
		logic [coh_bus_pkg::WORD_W-1:0]		data;
	} exp_t;

	logic							clk;
	logic							rst;
	logic [1:0]						req_en;
	req_t							cur_req [2];
	logic [1:0]						sup_vld;
	logic [coh_bus_pkg::WORD_W-1:0]	sup_data [2];
	wire [1:0]						ack;

	logic								bus_req_vld;
	logic								bus_req_id;
	logic [coh_bus_pkg::TAG_W-1:0]		bus_req_tag;
	logic [coh_bus_pkg::IDX_W-1:0]		bus_req_idx;
	coh_bus_pkg::message_t				bus_req_msg;
	logic [coh_bus_pkg::WORD_W-1:0]		bus_req_data;
	logic [coh_bus_pkg::RSP_Q_PTR_W-1:0]	bus_req_ptr;
	logic								bus_rsp_vld;
	logic								bus_rsp_id;
	logic [coh_bus_pkg::WORD_W-1:0]		bus_rsp_data;

	// shadow memory and block owner (0 none, 1 core0, 2 core1)
	logic [coh_bus_pkg::WORD_W-1:0]	shadow [coh_bus_pkg::MEM_WORDS];
	int								owner_of [coh_bus_pkg::MEM_WORDS];

	logic [31:0]	lfsr;
	req_t			cq0 [$];
	req_t			cq1 [$];
	exp_t			exp_q [$];
	logic [1:0]		acked;
	int				issued [2];
	int				ack_cnt [2];
	int				bcast_cnt;
	int				max_out;
	int				test_err;
	int				err_cnt;
	int				tests_run;
	int				tests_failed;
	string			cur_test;

	coh_bus_top dut0 (
		.clk					(clk),
		.rst					(rst),
		.core0_req_en_i			(req_en[0]),
		.core0_req_tag_i		(cur_req[0].blk[11:4]),
		.core0_req_idx_i		(cur_req[0].blk[3:0]),
		.core0_req_message_i	(cur_req[0].msg),
		.core0_req_data_i		(cur_req[0].data),
		.core0_rsp_vld_i		(sup_vld[0]),
		.core0_rsp_data_i		(sup_data[0]),
		.bus2core0_req_ack_o	(ack[0]),
		.core1_req_en_i			(req_en[1]),
		.core1_req_tag_i		(cur_req[1].blk[11:4]),
		.core1_req_idx_i		(cur_req[1].blk[3:0]),
		.core1_req_message_i	(cur_req[1].msg),
		.core1_req_data_i		(cur_req[1].data),
		.core1_rsp_vld_i		(sup_vld[1]),
		.core1_rsp_data_i		(sup_data[1]),
		.bus2core1_req_ack_o	(ack[1]),
		.bus_req_vld_o			(bus_req_vld),
		.bus_req_id_o			(bus_req_id),
		.bus_req_tag_o			(bus_req_tag),
		.bus_req_idx_o			(bus_req_idx),
		.bus_req_message_o		(bus_req_msg),
		.bus_req_data_o			(bus_req_data),
		.bus_req_ptr_o			(bus_req_ptr),
		.bus_rsp_vld_o			(bus_rsp_vld),
		.bus_rsp_id_o			(bus_rsp_id),
		.bus_rsp_data_o			(bus_rsp_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	// fibonacci LFSR with taps 32 22 2 1
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r		= {r[62:0], lfsr[31]};
			lfsr	= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		end
		return r;
	endfunction

	// what an owning core holds for a block
	function automatic logic [63:0] owner_word(input int n, input logic [11:0] blk);
		return {16'hc0de, n[7:0] + 8'd1, 28'h0, blk};
	endfunction

	// expected response for one accepted request
	function automatic exp_t expect_rsp(input logic id, input req_t r, input logic sup,
		input logic [63:0] sdata);
		exp_t e;
		e.blk	= r.blk;
		e.id	= id;
		if (r.msg == coh_bus_pkg::PUT_M) begin
			shadow[r.blk]	= r.data;
			e.data			= r.data;
		end else if (sup) begin
			e.data	= sdata;
		end else begin
			e.data	= shadow[r.blk];
		end
		return e;
	endfunction

	task automatic note_error(input string msg);
		$display("%s", msg);
		test_err++;
		err_cnt++;
	endtask

	task automatic queue_req(input int n, input coh_bus_pkg::message_t msg,
		input logic [11:0] blk, input logic [63:0] data);
		req_t r;
		r.msg	= msg;
		r.blk	= blk;
		r.data	= data;
		if (n == 0) begin
			cq0.push_back(r);
		end else begin
			cq1.push_back(r);
		end
	endtask

	// holds each request until the bus acknowledges it
	task automatic core_model(input int n);
		forever begin
			@(negedge clk);
			if (!req_en[n] || acked[n]) begin
				acked[n]	= 1'b0;
				req_en[n]	= 1'b0;
				if (n == 0 && cq0.size() > 0) begin
					cur_req[0]	= cq0.pop_front();
					req_en[0]	= 1'b1;
					issued[0]++;
				end else if (n == 1 && cq1.size() > 0) begin
					cur_req[1]	= cq1.pop_front();
					req_en[1]	= 1'b1;
					issued[1]++;
				end
			end
		end
	endtask

	task automatic check_idle();
		if (ack != 2'b00 || bus_req_vld || bus_rsp_vld) begin
			note_error($sformatf("%s: bus active before the first request", cur_test));
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		@(posedge clk);
	endtask

	task automatic wait_idle();
		@(negedge clk);
		while (cq0.size() != 0 || cq1.size() != 0 || req_en != 2'b00 || exp_q.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic finish_test();
		for (int i = 0; i < 2; i++) begin
			if (ack_cnt[i] != issued[i]) begin
				note_error($sformatf("ERROR %s core%0d acks expected %0d actual %0d",
					cur_test, i, issued[i], ack_cnt[i]));
			end
		end
		tests_run++;
		if (test_err != 0) begin
			tests_failed++;
		end
		$display("test %-14s %s, %0d errors", cur_test, (test_err == 0) ? "ok" : "failed",
			test_err);
		test_err	= 0;
		issued[0]	= 0;
		issued[1]	= 0;
		ack_cnt[0]	= 0;
		ack_cnt[1]	= 0;
	endtask

	initial core_model(0);
	initial core_model(1);

	// ----------------------------------------------------------------------
	// bus monitor, owner supply and expectations
	// ----------------------------------------------------------------------
	always @(negedge clk) begin : bus_monitor
		int n;
		int own;
		logic sup;
		logic [11:0] blk;
		logic [63:0] sdata;
		sup_vld = 2'b00;
		// settle after the core models drive
		#1;
		if (!rst) begin
			if (ack != 2'b00 && !bus_req_vld) begin
				note_error($sformatf("%s: acknowledge without a broadcast", cur_test));
			end
			for (int i = 0; i < 2; i++) begin
				if (ack[i]) begin
					ack_cnt[i]++;
				end
				if (ack[i] && !req_en[i]) begin
					note_error($sformatf("%s: core%0d acknowledged without a request",
						cur_test, i));
				end
			end
			if (bus_req_vld) begin
				n	= bus_req_id;
				blk	= cur_req[n].blk;
				if (ack != (2'b01 << n)) begin
					note_error($sformatf("%s: acknowledges disagree with broadcast id %0d",
						cur_test, n));
				end
				if ({bus_req_tag, bus_req_idx} != blk) begin
					note_error($sformatf("ERROR %s broadcast block expected %h actual %h",
						cur_test, blk, {bus_req_tag, bus_req_idx}));
				end
				if (bus_req_msg != cur_req[n].msg) begin
					note_error($sformatf("ERROR %s broadcast message expected %0d actual %0d",
						cur_test, cur_req[n].msg, bus_req_msg));
				end
				if (bus_req_data != cur_req[n].data) begin
					note_error($sformatf("ERROR %s broadcast data expected %h actual %h",
						cur_test, cur_req[n].data, bus_req_data));
				end
				// entries are handed out in order around the ring
				if (bus_req_ptr != bcast_cnt % coh_bus_pkg::RSP_Q_NUM) begin
					note_error($sformatf("ERROR %s broadcast ptr expected %0d actual %0d",
						cur_test, bcast_cnt % coh_bus_pkg::RSP_Q_NUM, bus_req_ptr));
				end
				bcast_cnt++;
				if (exp_q.size() >= coh_bus_pkg::RSP_Q_NUM) begin
					note_error($sformatf("%s: acknowledge with the queue full", cur_test));
				end
				for (int i = 0; i < exp_q.size(); i++) begin
					if (exp_q[i].blk == blk) begin
						note_error($sformatf("%s: block %h acknowledged while still pending",
							cur_test, blk));
					end
				end
				// a core other than the requester supplies a GET
				own		= owner_of[blk];
				sup		= (own != 0) && (own - 1 != n) && (cur_req[n].msg != coh_bus_pkg::PUT_M);
				sdata	= '0;
				if (sup) begin
					sdata				= owner_word(own - 1, blk);
					sup_data[own - 1]	= sdata;
					sup_vld[own - 1]	= 1'b1;
				end
				exp_q.push_back(expect_rsp(n[0], cur_req[n], sup, sdata));
				acked[n]	= 1'b1;
				if (exp_q.size() > max_out) begin
					max_out = exp_q.size();
				end
			end
		end
	end

	// responses in broadcast order
	always @(negedge clk) begin : rsp_checker
		exp_t e;
		if (!rst && bus_rsp_vld) begin
			if (exp_q.size() == 0) begin
				note_error($sformatf("%s: response with no request outstanding", cur_test));
			end else begin
				e = exp_q.pop_front();
				if (bus_rsp_id != e.id) begin
					note_error($sformatf("ERROR %s rsp id expected %0d actual %0d",
						cur_test, e.id, bus_rsp_id));
				end
				if (bus_rsp_data != e.data) begin
					note_error($sformatf("ERROR %s rsp data expected %h actual %h",
						cur_test, e.data, bus_rsp_data));
				end
			end
		end
	end

	initial begin
		repeat (WATCH_CYC) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCH_CYC);
		$display(">>> FAIL");
		$finish;
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin : main_seq
		logic [63:0] rb;
		logic [11:0] blk;
		logic [63:0] data;
		coh_bus_pkg::message_t msg;
		rst				= 1'b1;
		req_en			= 2'b00;
		sup_vld			= 2'b00;
		cur_req[0]		= '0;
		cur_req[1]		= '0;
		sup_data[0]		= '0;
		sup_data[1]		= '0;
		acked			= 2'b00;
		lfsr			= 32'h594a_18b8;
		issued[0]		= 0;
		issued[1]		= 0;
		ack_cnt[0]		= 0;
		ack_cnt[1]		= 0;
		bcast_cnt		= 0;
		max_out			= 0;
		test_err		= 0;
		err_cnt			= 0;
		tests_run		= 0;
		tests_failed	= 0;
		for (int i = 0; i < coh_bus_pkg::MEM_WORDS; i++) begin
			shadow[i]			= '0;
			shadow[i][11:0]		= i[11:0];
			owner_of[i]			= 0;
		end

		cur_test = "reset_idle";
		repeat (5) begin
			@(negedge clk);
			check_idle();
		end
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		finish_test();

		start_test("get_s_memory");
		queue_req(0, coh_bus_pkg::GET_S, 12'h123, '0);
		wait_idle();
		finish_test();

		start_test("get_m_owned");
		owner_of[12'h245] = 2;
		queue_req(0, coh_bus_pkg::GET_M, 12'h245, '0);
		wait_idle();
		finish_test();

		// second request waits behind the pending write back
		start_test("put_then_get");
		queue_req(1, coh_bus_pkg::PUT_M, 12'h3a7, 64'h1234_5678_9abc_def0);
		queue_req(1, coh_bus_pkg::GET_S, 12'h3a7, '0);
		wait_idle();
		finish_test();

		start_test("dual_distinct");
		queue_req(0, coh_bus_pkg::GET_S, 12'h510, '0);
		queue_req(1, coh_bus_pkg::GET_M, 12'h6e1, '0);
		wait_idle();
		finish_test();

		start_test("random_mix");
		// 16 blocks over tags 40..43 and indexes 8..b
		for (int i = 0; i < 16; i++) begin
			rb	= rand_bits(2);
			blk	= {6'h10, i[3:2], 2'b10, i[1:0]};
			owner_of[blk] = (rb[1:0] == 2'd1) ? 1 : ((rb[1:0] == 2'd2) ? 2 : 0);
		end
		max_out = 0;
		for (int i = 0; i < RND_REQS; i++) begin
			rb	= rand_bits(7);
			blk	= {6'h10, rb[5:4], 2'b10, rb[3:2]};
			case (rb[1:0])
				2'd1:		msg = coh_bus_pkg::GET_M;
				2'd2:		msg = coh_bus_pkg::PUT_M;
				default:	msg = coh_bus_pkg::GET_S;
			endcase
			data = (msg == coh_bus_pkg::PUT_M) ? rand_bits(64) : '0;
			queue_req(rb[6], msg, blk, data);
		end
		wait_idle();
		if (max_out < coh_bus_pkg::RSP_Q_NUM) begin
			note_error("random_mix: the response queue never filled up");
		end
		finish_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : coh_bus_tb

//--- coh_bus.f
coh_bus_pkg.sv
coh_bus_arbiter.sv
coh_rsp_queue.sv
coh_bus.sv
dmem_ctrl.sv
coh_bus_top.sv
coh_bus_tb.sv

//--- Bender.yml
package:
  name: coh_bus

sources:
  - coh_bus_pkg.sv
  - coh_bus_arbiter.sv
  - coh_rsp_queue.sv
  - coh_bus.sv
  - dmem_ctrl.sv
  - coh_bus_top.sv
  - target: test
    files:
      - coh_bus_tb.sv
